/* logic/xaui_mgmt_pkg.sv */
// Shared constants and the address union for the XAUI management subsystem.
// The PLL and CSR windows must not overlap. The decoder relies on that and
// steers each access to at most one slave.
// Timing constants are in phy_mgmt_clk cycles.

package xaui_mgmt_pkg;

  ////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////
  localparam int MGMT_ADDR_W = 8;                  // byte address
  localparam int MGMT_DATA_W = 32;                 // word data
  localparam int NUM_BYTES   = 8;                  // 4 lanes x 2 bytes

  ////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////
  localparam int SYNC_DEPTH    = 2;                // flops per sync chain
  localparam int PLL_PDN_HOLD  = 20;               // pll_pdn high time
  localparam int PLL_PDN_CNT_W = $clog2(PLL_PDN_HOLD); // hold counter width

  ////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////
  localparam logic [5:0] PLL_BASE       = 6'd4;    // 0x10..0x13
  localparam logic [1:0] PLL_REG_CTRL   = 2'd0;    // bit 0 starts pdn pulse
  localparam logic [1:0] PLL_REG_STATUS = 2'd1;    // {pdn, locked}

  localparam logic [2:0] CSR_BASE       = 3'd4;    // 0x80..0x9f
  localparam logic [4:0] CSR_REG_RESET  = 5'd0;    // {sim flag, tx rst, rx rst}
  localparam logic [4:0] CSR_REG_SYNC   = 5'd1;    // per-byte syncstatus
  localparam logic [4:0] CSR_REG_ERR    = 5'd2;    // sticky {disperr, errdetect}

  // one address byte, split two ways
  typedef union packed {
    logic [MGMT_ADDR_W-1:0] raw;                   // whole byte
    struct packed {
      logic [5:0] blk;                             // pll block select
      logic [1:0] ofs;                             // pll register offset
    } pll_view;
    struct packed {
      logic [2:0] blk;                             // csr block select
      logic [4:0] ofs;                             // csr register offset
    } csr_view;
  } mgmt_addr_u;

endpackage

/* logic/xaui_mgmt_decoder.sv */
// Management address decoder for the PLL and CSR slaves.
// Writes finish in the cycle they are seen. Reads always take two cycles,
// with waitrequest high in the first, including reads of unmapped space.
// The master must hold address and read stable while waitrequest is high.
`timescale 1ns/1ps

module xaui_mgmt_decoder (
  input  logic                                   phy_mgmt_clk,
  input  logic                                   rst,
  input  xaui_mgmt_pkg::mgmt_addr_u              phy_mgmt_address,
  input  logic                                   phy_mgmt_read,
  input  logic                                   phy_mgmt_write,
  input  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  pll_readdata,
  input  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  csr_readdata,
  output logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  phy_mgmt_readdata,
  output logic                                   phy_mgmt_waitrequest,
  output logic                                   pll_read,
  output logic                                   pll_write,
  output logic                                   csr_read,
  output logic                                   csr_write
);

  logic pll_hit;                                   // address in pll window
  logic csr_hit;                                   // address in csr window
  logic rd_busy;                                   // second read cycle
  logic rd_pll;                                    // pending read is pll
  logic rd_csr;                                    // pending read is csr
  logic rd_start;                                  // first read cycle

  ////////////////////////////////////////////////////
  // block select
  ////////////////////////////////////////////////////
  assign pll_hit = (phy_mgmt_address.pll_view.blk == xaui_mgmt_pkg::PLL_BASE);
  assign csr_hit = (phy_mgmt_address.csr_view.blk == xaui_mgmt_pkg::CSR_BASE);

  assign rd_start = phy_mgmt_read & ~rd_busy;      // new read this cycle

  // strobes are single cycle, reads only in the first cycle
  assign pll_write = phy_mgmt_write & pll_hit;
  assign csr_write = phy_mgmt_write & csr_hit;
  assign pll_read  = rd_start & pll_hit;
  assign csr_read  = rd_start & csr_hit;

  ////////////////////////////////////////////////////
  // pending read
  ////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (rst) begin
      rd_busy <= 1'b0;
      rd_pll  <= 1'b0;
      rd_csr  <= 1'b0;
    end else if (rd_busy) begin                    // data returned, done
      rd_busy <= 1'b0;
      rd_pll  <= 1'b0;
      rd_csr  <= 1'b0;
    end else if (phy_mgmt_read) begin
      rd_busy <= 1'b1;
      rd_pll  <= pll_hit;
      rd_csr  <= csr_hit;                          // neither set -> unmapped
    end
  end

  // stall exactly one cycle per read
  assign phy_mgmt_waitrequest = rd_start;

  ////////////////////////////////////////////////////
  // read data return
  ////////////////////////////////////////////////////
  always_comb begin
    if (rd_pll) begin
      phy_mgmt_readdata = pll_readdata;
    end else if (rd_csr) begin
      phy_mgmt_readdata = csr_readdata;
    end else begin
      phy_mgmt_readdata = '0;                      // idle or unmapped
    end
  end

endmodule

/* logic/xaui_pll_ctrl.sv */
// PLL control slave in the management clock domain.
// A write of bit 0 to the control register raises pll_pdn for a fixed
// number of cycles. A write during the pulse restarts the count.
// pll_locked may come from any domain and is synchronised here.
`timescale 1ns/1ps

module xaui_pll_ctrl (
  input  logic                                   phy_mgmt_clk,
  input  logic                                   rst,
  input  xaui_mgmt_pkg::mgmt_addr_u              address,
  input  logic                                   read,
  input  logic                                   write,
  input  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  writedata,
  input  logic                                   pll_locked,
  output logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  readdata,
  output logic                                   pll_pdn,
  output logic                                   tx_ready
);

  logic [xaui_mgmt_pkg::PLL_PDN_CNT_W-1:0] pdn_cnt;  // cycles left after this one
  logic [xaui_mgmt_pkg::SYNC_DEPTH-1:0]    lock_sync; // lock sync chain
  logic                                    locked_s;  // synced lock
  logic                                    pdn_start; // ctrl write, bit 0 set
  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]   rd_next;

  ////////////////////////////////////////////////////
  // power-down hold timer
  ////////////////////////////////////////////////////
  assign pdn_start = write
                   & (address.pll_view.ofs == xaui_mgmt_pkg::PLL_REG_CTRL)
                   & writedata[0];

  always_ff @(posedge phy_mgmt_clk) begin
    if (rst) begin
      pll_pdn <= 1'b0;
      pdn_cnt <= '0;
    end else if (pdn_start) begin                  // (re)load the hold
      pll_pdn <= 1'b1;
      pdn_cnt <= xaui_mgmt_pkg::PLL_PDN_CNT_W'(xaui_mgmt_pkg::PLL_PDN_HOLD - 1);
    end else if (pll_pdn) begin
      if (pdn_cnt == '0) begin
        pll_pdn <= 1'b0;                           // hold time used up
      end else begin
        pdn_cnt <= pdn_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // lock synchroniser
  ////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (rst) begin
      lock_sync <= '0;
    end else begin
      lock_sync <= {lock_sync[xaui_mgmt_pkg::SYNC_DEPTH-2:0], pll_locked};
    end
  end

  assign locked_s = lock_sync[xaui_mgmt_pkg::SYNC_DEPTH-1];

  // ready only once locked and not held in power-down
  assign tx_ready = locked_s & ~pll_pdn;

  ////////////////////////////////////////////////////
  // register read
  ////////////////////////////////////////////////////
  always_comb begin
    rd_next = '0;                                  // ctrl and spare read 0
    if (address.pll_view.ofs == xaui_mgmt_pkg::PLL_REG_STATUS) begin
      rd_next[0] = locked_s;
      rd_next[1] = pll_pdn;
    end
  end

  // one cycle after the strobe, held until the next read
  always_ff @(posedge phy_mgmt_clk) begin
    if (read) begin
      readdata <= rd_next;
    end
  end

endmodule

/* logic/xaui_pcs_csr.sv */
// PCS status and control slave.
// Holds the rx/tx digital reset bits and the simulation flag, and reports
// per-byte sync status and sticky error bits. Status inputs may change at
// any time and are synchronised before use. Sticky bits keep any event
// that arrives in the cycle of a clearing write.
`timescale 1ns/1ps

module xaui_pcs_csr (
  input  logic                                   phy_mgmt_clk,
  input  logic                                   rst,
  input  xaui_mgmt_pkg::mgmt_addr_u              address,
  input  logic                                   read,
  input  logic                                   write,
  input  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  writedata,
  input  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]    rx_syncstatus,
  input  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]    rx_errdetect,
  input  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]    rx_disperr,
  output logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  readdata,
  output logic                                   rx_digitalreset,
  output logic                                   tx_digitalreset,
  output logic                                   simulation_flag
);

  // sync chains, stage SYNC_DEPTH-1 is the output
  logic [xaui_mgmt_pkg::SYNC_DEPTH-1:0][xaui_mgmt_pkg::NUM_BYTES-1:0] ss_sync;
  logic [xaui_mgmt_pkg::SYNC_DEPTH-1:0][xaui_mgmt_pkg::NUM_BYTES-1:0] ed_sync;
  logic [xaui_mgmt_pkg::SYNC_DEPTH-1:0][xaui_mgmt_pkg::NUM_BYTES-1:0] de_sync;

  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]   ed_sticky;  // errdetect seen
  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]   de_sticky;  // disperr seen
  logic                                  wr_reset;   // write to reset reg
  logic                                  wr_err;     // write to err reg
  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0] rd_next;

  assign wr_reset = write & (address.csr_view.ofs == xaui_mgmt_pkg::CSR_REG_RESET);
  assign wr_err   = write & (address.csr_view.ofs == xaui_mgmt_pkg::CSR_REG_ERR);

  ////////////////////////////////////////////////////
  // reset and flag control register
  ////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (rst) begin
      rx_digitalreset <= 1'b0;
      tx_digitalreset <= 1'b0;
      simulation_flag <= 1'b0;
    end else if (wr_reset) begin
      rx_digitalreset <= writedata[0];
      tx_digitalreset <= writedata[1];
      simulation_flag <= writedata[2];             // shortens soft pcs timers
    end
  end

  ////////////////////////////////////////////////////
  // status synchronisers
  ////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (rst) begin
      ss_sync <= '0;
      ed_sync <= '0;
      de_sync <= '0;
    end else begin
      ss_sync[0] <= rx_syncstatus;                 // first stage, metastable
      ed_sync[0] <= rx_errdetect;
      de_sync[0] <= rx_disperr;
      for (int i = 1; i < xaui_mgmt_pkg::SYNC_DEPTH; i++) begin
        ss_sync[i] <= ss_sync[i-1];
        ed_sync[i] <= ed_sync[i-1];
        de_sync[i] <= de_sync[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////
  // sticky error bits
  ////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk) begin
    if (rst) begin
      ed_sticky <= '0;
      de_sticky <= '0;
    end else begin
      // clear on write, new events still land
      ed_sticky <= (wr_err ? '0 : ed_sticky) | ed_sync[xaui_mgmt_pkg::SYNC_DEPTH-1];
      de_sticky <= (wr_err ? '0 : de_sticky) | de_sync[xaui_mgmt_pkg::SYNC_DEPTH-1];
    end
  end

  ////////////////////////////////////////////////////
  // register read
  ////////////////////////////////////////////////////
  always_comb begin
    rd_next = '0;                                  // unused offsets read 0
    case (address.csr_view.ofs)
      xaui_mgmt_pkg::CSR_REG_RESET: begin
        rd_next[0] = rx_digitalreset;
        rd_next[1] = tx_digitalreset;
        rd_next[2] = simulation_flag;
      end
      xaui_mgmt_pkg::CSR_REG_SYNC: begin
        rd_next[xaui_mgmt_pkg::NUM_BYTES-1:0] = ss_sync[xaui_mgmt_pkg::SYNC_DEPTH-1];
      end
      xaui_mgmt_pkg::CSR_REG_ERR: begin
        rd_next[xaui_mgmt_pkg::NUM_BYTES-1:0]                         = ed_sticky;
        rd_next[2*xaui_mgmt_pkg::NUM_BYTES-1:xaui_mgmt_pkg::NUM_BYTES] = de_sticky;
      end
      default: begin
        rd_next = '0;
      end
    endcase
  end

  // captured on the strobe, decoder returns it next cycle
  always_ff @(posedge phy_mgmt_clk) begin
    if (read) begin
      readdata <= rd_next;
    end
  end

endmodule

/* logic/xaui_mgmt_top.sv */
// Management register subsystem of a four-lane XAUI PHY wrapper.
// One read/write/waitrequest port serves the PLL control and PCS CSR slaves.
// All logic runs on phy_mgmt_clk with a synchronous active-high reset.
`timescale 1ns/1ps

module xaui_mgmt_top (
  input  logic                                   phy_mgmt_clk,
  input  logic                                   rst,
  input  logic [xaui_mgmt_pkg::MGMT_ADDR_W-1:0]  phy_mgmt_address,
  input  logic                                   phy_mgmt_read,
  input  logic                                   phy_mgmt_write,
  input  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  phy_mgmt_writedata,
  output logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  phy_mgmt_readdata,
  output logic                                   phy_mgmt_waitrequest,
  input  logic                                   pll_locked,
  output logic                                   pll_pdn,
  output logic                                   tx_ready,
  input  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]    rx_syncstatus,
  input  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]    rx_errdetect,
  input  logic [xaui_mgmt_pkg::NUM_BYTES-1:0]    rx_disperr,
  output logic                                   rx_digitalreset,
  output logic                                   tx_digitalreset,
  output logic                                   simulation_flag
);

  logic                                  pll_read;     // pll strobes
  logic                                  pll_write;
  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0] pll_readdata;
  logic                                  csr_read;     // csr strobes
  logic                                  csr_write;
  logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0] csr_readdata;

  ////////////////////////////////////////////////////
  // address decoder
  ////////////////////////////////////////////////////
  xaui_mgmt_decoder xaui_mgmt_decoder_inst (
    .phy_mgmt_clk         (phy_mgmt_clk),
    .rst                  (rst),
    .phy_mgmt_address     (phy_mgmt_address),
    .phy_mgmt_read        (phy_mgmt_read),
    .phy_mgmt_write       (phy_mgmt_write),
    .pll_readdata         (pll_readdata),
    .csr_readdata         (csr_readdata),
    .phy_mgmt_readdata    (phy_mgmt_readdata),
    .phy_mgmt_waitrequest (phy_mgmt_waitrequest),
    .pll_read             (pll_read),
    .pll_write            (pll_write),
    .csr_read             (csr_read),
    .csr_write            (csr_write)
  );

  ////////////////////////////////////////////////////
  // slaves, address and data shared
  ////////////////////////////////////////////////////
  xaui_pll_ctrl xaui_pll_ctrl_inst (
    .phy_mgmt_clk (phy_mgmt_clk),
    .rst          (rst),
    .address      (phy_mgmt_address),
    .read         (pll_read),
    .write        (pll_write),
    .writedata    (phy_mgmt_writedata),
    .pll_locked   (pll_locked),
    .readdata     (pll_readdata),
    .pll_pdn      (pll_pdn),
    .tx_ready     (tx_ready)
  );

  xaui_pcs_csr xaui_pcs_csr_inst (
    .phy_mgmt_clk    (phy_mgmt_clk),
    .rst             (rst),
    .address         (phy_mgmt_address),
    .read            (csr_read),
    .write           (csr_write),
    .writedata       (phy_mgmt_writedata),
    .rx_syncstatus   (rx_syncstatus),
    .rx_errdetect    (rx_errdetect),
    .rx_disperr      (rx_disperr),
    .readdata        (csr_readdata),
    .rx_digitalreset (rx_digitalreset),
    .tx_digitalreset (tx_digitalreset),
    .simulation_flag (simulation_flag)
  );

endmodule

/* dv/xaui_mgmt_asserts.sv */
// Bus and PLL timing assertions, bound to the management top level.
// The pll_pdn length check restarts its count on every control write
// with bit 0 set, so a restarted pulse is not flagged.
`timescale 1ns/1ps

module xaui_mgmt_asserts (
  input logic                                   phy_mgmt_clk,
  input logic                                   rst,
  input logic [xaui_mgmt_pkg::MGMT_ADDR_W-1:0]  phy_mgmt_address,
  input logic                                   phy_mgmt_read,
  input logic                                   phy_mgmt_write,
  input logic [xaui_mgmt_pkg::MGMT_DATA_W-1:0]  phy_mgmt_writedata,
  input logic                                   phy_mgmt_waitrequest,
  input logic                                   pll_pdn,
  input logic                                   tx_ready
);

  logic pdn_kick;                                  // ctrl write starting a pulse
  int   pdn_run;                                   // high cycles since last kick

  assign pdn_kick = phy_mgmt_write & phy_mgmt_writedata[0]
                  & (phy_mgmt_address == {xaui_mgmt_pkg::PLL_BASE,
                                          xaui_mgmt_pkg::PLL_REG_CTRL});

  always_ff @(posedge phy_mgmt_clk) begin
    if (rst || pdn_kick || !pll_pdn) begin
      pdn_run <= 0;
    end else begin
      pdn_run <= pdn_run + 1;
    end
  end

  ////////////////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////////////////
  wait_once: assert property (@(posedge phy_mgmt_clk) disable iff (rst)
    phy_mgmt_waitrequest |=> !phy_mgmt_waitrequest)
    else $error("waitrequest high in two consecutive cycles");

  wait_has_read: assert property (@(posedge phy_mgmt_clk) disable iff (rst)
    phy_mgmt_waitrequest |-> phy_mgmt_read)
    else $error("waitrequest high without a read");

  ////////////////////////////////////////////////////
  // pll power-down
  ////////////////////////////////////////////////////
  pdn_length: assert property (@(posedge phy_mgmt_clk) disable iff (rst)
    pll_pdn |-> (pdn_run < xaui_mgmt_pkg::PLL_PDN_HOLD))
    else $error("pll_pdn held longer than the hold time");

  ready_in_pdn: assert property (@(posedge phy_mgmt_clk) disable iff (rst)
    !(tx_ready && pll_pdn))
    else $error("tx_ready high during pll power-down");

endmodule

bind xaui_mgmt_top xaui_mgmt_asserts xaui_mgmt_asserts_inst (
  .phy_mgmt_clk         (phy_mgmt_clk),
  .rst                  (rst),
  .phy_mgmt_address     (phy_mgmt_address),
  .phy_mgmt_read        (phy_mgmt_read),
  .phy_mgmt_write       (phy_mgmt_write),
  .phy_mgmt_writedata   (phy_mgmt_writedata),
  .phy_mgmt_waitrequest (phy_mgmt_waitrequest),
  .pll_pdn              (pll_pdn),
  .tx_ready             (tx_ready)
);

/* dv/xaui_mgmt_tb.sv */
// Testbench for the XAUI management subsystem, random stimulus with seed 16.
// Inputs change on the falling clock edge and outputs are sampled there too.
// The model assumes pll_locked stays low until the PLL section at the end.
`timescale 1ns/1ps

module xaui_mgmt_tb;

  logic        phy_mgmt_clk;
  logic        rst;
  logic [7:0]  phy_mgmt_address;
  logic        phy_mgmt_read;
  logic        phy_mgmt_write;
  logic [31:0] phy_mgmt_writedata;
  logic [31:0] phy_mgmt_readdata;
  logic        phy_mgmt_waitrequest;
  logic        pll_locked;
  logic        pll_pdn;
  logic        tx_ready;
  logic [7:0]  rx_syncstatus;
  logic [7:0]  rx_errdetect;
  logic [7:0]  rx_disperr;
  logic        rx_digitalreset;
  logic        tx_digitalreset;
  logic        simulation_flag;

  integer      seed = 16;
  int          max_wait = 100;                     // cycles before a wait gives up
  int          errors = 0;
  int          timeouts = 0;
  int          pulse_len;
  logic [31:0] r;
  logic [31:0] d;
  logic [7:0]  a;
  logic [7:0]  e;
  logic [7:0]  p;
  logic [2:0]  m_ctrl;                             // model of the csr reset reg
  logic [7:0]  m_sync;                             // last driven syncstatus
  logic [7:0]  m_ed;                               // sticky errdetect
  logic [7:0]  m_de;                               // sticky disperr
  logic        m_lock;
  logic        m_pdn;

  xaui_mgmt_top xaui_mgmt_top_inst (.*);

  initial begin
    phy_mgmt_clk = 1'b0;
    forever #5 phy_mgmt_clk = ~phy_mgmt_clk;       // 10 ns period
  end

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////
  function automatic logic [7:0] pll_addr(input logic [1:0] ofs);
    return {xaui_mgmt_pkg::PLL_BASE, ofs};
  endfunction

  function automatic logic [7:0] csr_addr(input logic [4:0] ofs);
    return {xaui_mgmt_pkg::CSR_BASE, ofs};
  endfunction

  // read data predicted from the address map and the model state
  function automatic logic [31:0] expected_data(input logic [7:0] addr);
    logic [31:0] v;
    v = '0;
    if (addr[7:2] == xaui_mgmt_pkg::PLL_BASE && addr[1:0] == xaui_mgmt_pkg::PLL_REG_STATUS) begin
      v = {30'd0, m_pdn, m_lock};
    end else if (addr[7:5] == xaui_mgmt_pkg::CSR_BASE) begin
      case (addr[4:0])
        xaui_mgmt_pkg::CSR_REG_RESET: v = {29'd0, m_ctrl};
        xaui_mgmt_pkg::CSR_REG_SYNC:  v = {24'd0, m_sync};
        xaui_mgmt_pkg::CSR_REG_ERR:   v = {16'd0, m_de, m_ed};
        default:                      v = '0;      // spare csr offsets
      endcase
    end
    return v;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge phy_mgmt_clk);
  endtask

  task automatic wait_accept(output int cycles);
    cycles = 0;
    while (phy_mgmt_waitrequest && cycles < max_wait) begin
      @(negedge phy_mgmt_clk);
      cycles++;
    end
    if (phy_mgmt_waitrequest) begin
      $display("timeout: waitrequest stayed high for %0d cycles", max_wait);
      timeouts++;
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!tx_ready && cycles < max_wait) begin
      @(negedge phy_mgmt_clk);
      cycles++;
    end
    if (!tx_ready) begin
      $display("timeout: tx_ready did not rise within %0d cycles", max_wait);
      timeouts++;
    end
  endtask

  // starts and ends on a falling edge, updates the model
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    int cycles;
    phy_mgmt_address   = addr;
    phy_mgmt_writedata = data;
    phy_mgmt_write     = 1'b1;
    #1;
    wait_accept(cycles);
    check(cycles, 0, "write wait cycles");         // writes never stall
    @(negedge phy_mgmt_clk);
    phy_mgmt_write = 1'b0;
    if (addr == csr_addr(xaui_mgmt_pkg::CSR_REG_RESET)) begin
      m_ctrl = data[2:0];
    end
    if (addr == csr_addr(xaui_mgmt_pkg::CSR_REG_ERR)) begin
      m_ed = '0;                                   // any write clears
      m_de = '0;
    end
    check({simulation_flag, tx_digitalreset, rx_digitalreset}, m_ctrl, "control outputs");
  endtask

  task automatic read_check(input logic [7:0] addr, input string what);
    int          cycles;
    logic [31:0] exp;
    exp              = expected_data(addr);
    phy_mgmt_address = addr;
    phy_mgmt_read    = 1'b1;
    #1;
    check(phy_mgmt_waitrequest, 1, {what, ": waitrequest in first cycle"});
    wait_accept(cycles);
    check(cycles, 1, {what, ": wait cycles"});    // one wait plus one data cycle
    check(phy_mgmt_readdata, exp, what);
    @(negedge phy_mgmt_clk);                       // hold read through the data cycle
    phy_mgmt_read = 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////
  initial begin
    rst = 1'b1;
    phy_mgmt_address = '0;
    phy_mgmt_read = 1'b0;
    phy_mgmt_write = 1'b0;
    phy_mgmt_writedata = '0;
    pll_locked = 1'b0;
    rx_syncstatus = '0;
    rx_errdetect = '0;
    rx_disperr = '0;
    {m_ctrl, m_sync, m_ed, m_de, m_lock, m_pdn} = '0;
    repeat (3) @(posedge phy_mgmt_clk);
    @(negedge phy_mgmt_clk);
    rst = 1'b0;

    // reset values
    check({pll_pdn, tx_ready, simulation_flag, tx_digitalreset, rx_digitalreset}, 0,
          "outputs after reset");
    read_check(pll_addr(xaui_mgmt_pkg::PLL_REG_CTRL), "pll ctrl after reset");
    read_check(pll_addr(xaui_mgmt_pkg::PLL_REG_STATUS), "pll status after reset");
    read_check(csr_addr(xaui_mgmt_pkg::CSR_REG_RESET), "csr reset after reset");
    read_check(csr_addr(xaui_mgmt_pkg::CSR_REG_SYNC), "csr sync after reset");
    read_check(csr_addr(xaui_mgmt_pkg::CSR_REG_ERR), "csr err after reset");

    // random mix over mapped and unmapped space
    repeat (300) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:          a = pll_addr(r[9:8]);
        3'd1, 3'd2, 3'd3: a = csr_addr(5'(r[9:8] % 3));
        3'd4:          a = csr_addr(r[12:8]);      // includes spare offsets
        default:       a = r[15:8];                // mostly unmapped
      endcase
      d = $random(seed);
      if (a[7:2] == xaui_mgmt_pkg::PLL_BASE) d[0] = 1'b0; // no pdn pulse here
      if (r[16]) write_reg(a, d);
      else read_check(a, "random read");
    end

    // sync status
    repeat (20) begin
      rx_syncstatus = $random(seed);
      m_sync = rx_syncstatus;
      idle(4);                                     // let the sync chain settle
      read_check(csr_addr(xaui_mgmt_pkg::CSR_REG_SYNC), "sync status");
    end

    // sticky errors
    repeat (12) begin
      e = $random(seed);
      p = $random(seed);
      rx_errdetect = e;
      rx_disperr = p;
      m_ed = m_ed | e;
      m_de = m_de | p;
      idle(3 + ($random(seed) & 3));
      rx_errdetect = '0;
      rx_disperr = '0;
      idle(3);                                     // drain the sync chain
      read_check(csr_addr(xaui_mgmt_pkg::CSR_REG_ERR), "sticky errors");
      if ($random(seed) & 1) begin
        write_reg(csr_addr(xaui_mgmt_pkg::CSR_REG_ERR), $random(seed));
        read_check(csr_addr(xaui_mgmt_pkg::CSR_REG_ERR), "sticky after clear");
      end
    end

    // pll power-down pulse
    check(pll_pdn, 0, "pll_pdn before pulse");
    write_reg(pll_addr(xaui_mgmt_pkg::PLL_REG_CTRL), 32'h1);
    pulse_len = 0;
    while (pll_pdn && pulse_len < max_wait) begin
      pulse_len++;
      @(negedge phy_mgmt_clk);
    end
    check(pulse_len, xaui_mgmt_pkg::PLL_PDN_HOLD, "pll_pdn pulse length");
    pll_locked = 1'b1;
    m_lock = 1'b1;
    wait_ready();
    read_check(pll_addr(xaui_mgmt_pkg::PLL_REG_STATUS), "pll status locked");
    write_reg(pll_addr(xaui_mgmt_pkg::PLL_REG_CTRL), $random(seed) | 1);
    m_pdn = 1'b1;
    check(tx_ready, 0, "tx_ready during pulse");
    read_check(pll_addr(xaui_mgmt_pkg::PLL_REG_STATUS), "pll status in pulse");
    m_pdn = 1'b0;
    wait_ready();                                  // rises once the pulse ends
    check(pll_pdn, 0, "pll_pdn after pulse");
    read_check(pll_addr(xaui_mgmt_pkg::PLL_REG_STATUS), "pll status after pulse");

    idle(2);
    $display("run complete: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
logic/xaui_mgmt_pkg.sv
logic/xaui_mgmt_decoder.sv
logic/xaui_pll_ctrl.sv
logic/xaui_pcs_csr.sv
logic/xaui_mgmt_top.sv
dv/xaui_mgmt_asserts.sv
dv/xaui_mgmt_tb.sv
